// ==== include/ifetch_cfg.svh ====
/*
  Build-time sizes, opcodes and thresholds for the instruction fetch stage.
  Include this header wherever one of these values is needed.
*/
`ifndef IFETCH_CFG_SVH
`define IFETCH_CFG_SVH

// Instruction memory size in bytes
`define IFETCH_IMEM_SIZE_BYTE 4096

// Byte address width, which covers the whole IMEM
`define IFETCH_ADDR_W ($clog2(`IFETCH_IMEM_SIZE_BYTE))

// Data and integrity widths of one IMEM word
`define IFETCH_INSN_W 32
`define IFETCH_INTG_W 7
`define IFETCH_WORD_W (`IFETCH_INSN_W + `IFETCH_INTG_W)

// Base opcodes that change control flow
`define IFETCH_OPC_BRANCH 7'b1100011
`define IFETCH_OPC_JAL    7'b1101111
`define IFETCH_OPC_JALR   7'b1100111

// Width of the loop iteration counter
`define IFETCH_LOOP_W 32

`endif

// ==== source/ifetch_pkg.sv ====
/*
  Shared types for the instruction fetch stage.
  Modules pull these in with a wildcard import in their header.
*/
`include "ifetch_cfg.svh"

package ifetch_pkg;

  // Byte address into IMEM
  typedef logic [`IFETCH_ADDR_W-1:0] imem_addr_t;

  // Loop end address carries one extra bit
  // It lets a loop end just past the top of IMEM
  typedef logic [`IFETCH_ADDR_W:0] loop_end_addr_t;

  // Instruction without integrity bits
  typedef logic [`IFETCH_INSN_W-1:0] insn_t;

  // Full IMEM word
  // Bits 31..0 hold the instruction, bits 38..32 the integrity code
  typedef logic [`IFETCH_WORD_W-1:0] imem_word_t;

  // Integrity error vector
  // Bit 0 flags a single disagreeing check bit, bit 1 flags several
  typedef logic [1:0] intg_err_t;

endpackage

// ==== source/ifetch_intg_check.sv ====
/*
  Combinational integrity check of one IMEM word.
  Recomputes the inverted interleaved parity and classifies disagreements.
*/
`include "ifetch_cfg.svh"

module ifetch_intg_check
  import ifetch_pkg::*;
(
  input  imem_word_t word_i,
  output intg_err_t  err_o
);

  logic [`IFETCH_INTG_W-1:0] calc_intg;
  logic [`IFETCH_INTG_W-1:0] syndrome;
  logic [2:0]                num_diff;

  // Check bit k covers every data bit whose index mod 7 equals k
  // Starting from all ones gives the inverted parity directly
  always_comb begin
    calc_intg = '1;
    for (int i = 0; i < `IFETCH_INSN_W; i++) begin
      calc_intg[i % `IFETCH_INTG_W] ^= word_i[i];
    end
  end

  // Stored check bits sit above the data field
  assign syndrome = calc_intg ^ word_i[`IFETCH_WORD_W-1:`IFETCH_INSN_W];

  // Count how many check bits disagree
  always_comb begin
    num_diff = '0;
    for (int k = 0; k < `IFETCH_INTG_W; k++) begin
      num_diff += {2'b00, syndrome[k]};
    end
  end

  // One disagreement is reported apart from several
  assign err_o[0] = (num_diff == 3'd1);
  assign err_o[1] = (num_diff > 3'd1);

endmodule

// ==== source/ifetch_prefetch.sv ====
/*
  Prefetcher of the fetch stage: picks the next IMEM address, holds the prefetch
  address, kills the read after a branch and flags requests at the wrong address.
*/
`include "ifetch_cfg.svh"

module ifetch_prefetch
  import ifetch_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      prefetch_en_i,
  input  logic                      insn_fetch_req_valid_raw_i,
  input  imem_addr_t                insn_fetch_req_addr_i,

  input  imem_word_t                imem_rdata_i,
  input  logic                      imem_rvalid_i,

  input  logic                      prefetch_loop_active_i,
  input  logic [`IFETCH_LOOP_W-1:0] prefetch_loop_iterations_i,
  input  loop_end_addr_t            prefetch_loop_end_addr_i,
  input  imem_addr_t                prefetch_loop_jump_addr_i,
  input  logic                      prefetch_ignore_errs_i,

  output logic                      imem_req_o,
  output imem_addr_t                imem_addr_o,
  output imem_addr_t                prefetch_addr_o,
  output logic                      rvalid_final_o,
  output logic                      insn_addr_err_o
);

  // True for any opcode that may redirect the program counter
  function automatic logic is_ctrl_flow(imem_word_t word);
    logic [6:0] opc;
    opc = word[6:0];
    return opc inside {`IFETCH_OPC_BRANCH, `IFETCH_OPC_JAL, `IFETCH_OPC_JALR};
  endfunction

  imem_addr_t prefetch_addr_q;
  logic       prefetch_ld;
  logic       prefetch_miss;
  logic       addr_differs;
  logic       loop_hit;
  logic       kill_d;
  logic       kill_q;

  // A read that returns right after a control-flow word is thrown away
  assign rvalid_final_o = imem_rvalid_i & ~kill_q;

  assign addr_differs = (insn_fetch_req_addr_i != prefetch_addr_q);

  // The raw request keeps error gating out of the address mux timing path
  // A miss means nothing usable came back, or it came back for another address
  assign prefetch_miss = insn_fetch_req_valid_raw_i & (~rvalid_final_o | addr_differs);

  // The loop end compare uses the widened address so the extra bit must be zero
  assign loop_hit = ({1'b0, prefetch_addr_q} == prefetch_loop_end_addr_i) &&
                    prefetch_loop_active_i &&
                    (prefetch_loop_iterations_i > `IFETCH_LOOP_W'(1));

  // Next address selection, highest priority first
  always_comb begin
    // Sequential fetch is the default
    imem_addr_o = prefetch_addr_q + imem_addr_t'(4);
    kill_d      = 1'b0;
    prefetch_ld = prefetch_en_i;

    if (!insn_fetch_req_valid_raw_i) begin
      // The executor is stalled so keep reading the word it will want next
      imem_addr_o = prefetch_addr_q;
    end else if (prefetch_miss) begin
      // Recover by reading exactly what was asked for
      imem_addr_o = insn_fetch_req_addr_i;
    end else if (is_ctrl_flow(imem_rdata_i)) begin
      // Taken or not is unknown here, so prefetch nothing and drop the next read
      // This keeps timing the same for both outcomes
      kill_d      = 1'b1;
      prefetch_ld = 1'b0;
    end else if (loop_hit) begin
      // More iterations remain so go back to the loop body start
      imem_addr_o = prefetch_loop_jump_addr_i;
    end
  end

  // The prefetch address tracks the address whose read is in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prefetch_addr_q <= '0;
    end else if (prefetch_ld) begin
      prefetch_addr_q <= imem_addr_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kill_q <= 1'b0;
    end else begin
      kill_q <= kill_d;
    end
  end

  // IMEM is read every cycle the controller enables prefetching
  assign imem_req_o      = prefetch_en_i;
  assign prefetch_addr_o = prefetch_addr_q;

  // The prefetcher is either right or does not prefetch
  // A returning word at another address than requested points to a fault
  assign insn_addr_err_o = rvalid_final_o & insn_fetch_req_valid_raw_i &
                           ~prefetch_ignore_errs_i & addr_differs;

  // Instructions are word aligned, so IMEM must only see aligned addresses
  a_imem_addr_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    imem_req_o |-> (imem_addr_o[1:0] == 2'b00)
  );

endmodule

// ==== source/ifetch_resp.sv ====
/*
  Response stage of the fetch unit: registers the matching IMEM word and its
  address, and reports integrity errors on the registered word.
*/
`include "ifetch_cfg.svh"

module ifetch_resp
  import ifetch_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       insn_fetch_req_valid_i,
  input  imem_addr_t insn_fetch_req_addr_i,
  input  logic       insn_fetch_resp_clear_i,

  input  imem_word_t imem_rdata_i,
  input  logic       rvalid_final_i,
  input  imem_addr_t prefetch_addr_i,

  output logic       insn_fetch_resp_valid_o,
  output imem_addr_t insn_fetch_resp_addr_o,
  output insn_t      insn_fetch_resp_data_o,
  output logic       insn_fetch_err_o
);

  logic       fetch_en;
  logic       resp_valid_d;
  logic       resp_valid_q;
  imem_word_t resp_word_q;
  imem_addr_t resp_addr_q;
  intg_err_t  intg_err;

  // Only a prefetch that matches the qualified request becomes a response
  assign fetch_en = insn_fetch_req_valid_i & rvalid_final_i &
                    (insn_fetch_req_addr_i == prefetch_addr_i);

  // With a request, validity follows the match
  // Without one, valid holds until the executor clears it
  assign resp_valid_d = insn_fetch_req_valid_i ? fetch_en :
                                                 resp_valid_q & ~insn_fetch_resp_clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= resp_valid_d;
    end
  end

  // The word keeps its check bits so integrity is checked after the register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_word_q <= '0;
    end else if (fetch_en) begin
      resp_word_q <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_en) begin
      resp_addr_q <= prefetch_addr_i;
    end
  end

  ifetch_intg_check u_intg_check (
    .word_i(resp_word_q),
    .err_o (intg_err)
  );

  assign insn_fetch_resp_valid_o = resp_valid_q;
  assign insn_fetch_resp_addr_o  = resp_addr_q;

  // Check bits are stripped before the instruction goes to decode
  assign insn_fetch_resp_data_o  = resp_word_q[`IFETCH_INSN_W-1:0];

  // Any error class counts, but only for a valid response
  assign insn_fetch_err_o = (|intg_err) & resp_valid_q;

endmodule

// ==== source/ifetch_top.sv ====
/*
  Instruction fetch stage top level.
  Connects the prefetcher and the response stage to the IMEM and executor ports.
*/
`include "ifetch_cfg.svh"

module ifetch_top
  import ifetch_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Fetch request from the executor
  input  logic                      insn_fetch_req_valid_i,
  input  logic                      insn_fetch_req_valid_raw_i,
  input  imem_addr_t                insn_fetch_req_addr_i,
  input  logic                      insn_fetch_resp_clear_i,

  // Prefetch control from the controller
  input  logic                      prefetch_en_i,
  input  logic                      prefetch_loop_active_i,
  input  logic [`IFETCH_LOOP_W-1:0] prefetch_loop_iterations_i,
  input  loop_end_addr_t            prefetch_loop_end_addr_i,
  input  imem_addr_t                prefetch_loop_jump_addr_i,
  input  logic                      prefetch_ignore_errs_i,

  // IMEM read port
  output logic                      imem_req_o,
  output imem_addr_t                imem_addr_o,
  input  imem_word_t                imem_rdata_i,
  input  logic                      imem_rvalid_i,

  // Fetch response and faults
  output logic                      insn_fetch_resp_valid_o,
  output imem_addr_t                insn_fetch_resp_addr_o,
  output insn_t                     insn_fetch_resp_data_o,
  output logic                      insn_fetch_err_o,
  output logic                      insn_addr_err_o
);

  // Read-valid after the kill mask, and the address that read belongs to
  logic       rvalid_final;
  imem_addr_t prefetch_addr;

  ifetch_prefetch u_prefetch (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .prefetch_en_i             (prefetch_en_i),
    .insn_fetch_req_valid_raw_i(insn_fetch_req_valid_raw_i),
    .insn_fetch_req_addr_i     (insn_fetch_req_addr_i),
    .imem_rdata_i              (imem_rdata_i),
    .imem_rvalid_i             (imem_rvalid_i),
    .prefetch_loop_active_i    (prefetch_loop_active_i),
    .prefetch_loop_iterations_i(prefetch_loop_iterations_i),
    .prefetch_loop_end_addr_i  (prefetch_loop_end_addr_i),
    .prefetch_loop_jump_addr_i (prefetch_loop_jump_addr_i),
    .prefetch_ignore_errs_i    (prefetch_ignore_errs_i),
    .imem_req_o                (imem_req_o),
    .imem_addr_o               (imem_addr_o),
    .prefetch_addr_o           (prefetch_addr),
    .rvalid_final_o            (rvalid_final),
    .insn_addr_err_o           (insn_addr_err_o)
  );

  ifetch_resp u_resp (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .insn_fetch_req_valid_i (insn_fetch_req_valid_i),
    .insn_fetch_req_addr_i  (insn_fetch_req_addr_i),
    .insn_fetch_resp_clear_i(insn_fetch_resp_clear_i),
    .imem_rdata_i           (imem_rdata_i),
    .rvalid_final_i         (rvalid_final),
    .prefetch_addr_i        (prefetch_addr),
    .insn_fetch_resp_valid_o(insn_fetch_resp_valid_o),
    .insn_fetch_resp_addr_o (insn_fetch_resp_addr_o),
    .insn_fetch_resp_data_o (insn_fetch_resp_data_o),
    .insn_fetch_err_o       (insn_fetch_err_o)
  );

endmodule

// ==== include/ifetch_tb_table.svh ====
/*
  Stimulus table for the fetch stage testbench, one row per clock cycle.
  Included into the testbench module, where add_row collects the rows.
*/
`ifndef IFETCH_TB_TABLE_SVH
`define IFETCH_TB_TABLE_SVH

// Columns: req valid, raw valid, req addr, clear, prefetch en, loop active,
// loop count, loop end, loop jump, ignore errs, error class (bit0 intg, bit1 addr)
task automatic load_table();
  // Sequential fetch from address 0, first request misses and re-fetches
  add_row(1, 1, 12'h000, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(1, 1, 12'h000, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(1, 1, 12'h004, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(1, 1, 12'h008, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Word at 0x008 carries one flipped check bit
  add_row(1, 1, 12'h00c, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd1);
  // Stall, the word at 0x00c with two flipped bits stays on the response
  add_row(0, 0, 12'h010, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd1);
  add_row(0, 0, 12'h010, 1, 1, 0, 0, 13'h000, 12'h000, 0, 2'd1);
  // Clear has dropped valid, so the error is gated off
  add_row(1, 1, 12'h010, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Branch word at 0x014, then a taken branch to 0x040
  add_row(1, 1, 12'h014, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(1, 1, 12'h040, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(1, 1, 12'h040, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Loop body 0x040..0x044, jump back while more than one pass remains
  add_row(1, 1, 12'h044, 0, 1, 1, 3, 13'h044, 12'h040, 0, 2'd0);
  add_row(1, 1, 12'h040, 0, 1, 1, 2, 13'h044, 12'h040, 0, 2'd0);
  add_row(1, 1, 12'h044, 0, 1, 1, 1, 13'h044, 12'h040, 0, 2'd0);
  add_row(1, 1, 12'h048, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Raw request at another address than the returning prefetch
  add_row(0, 1, 12'h064, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd2);
  add_row(1, 1, 12'h064, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Same kind of fault, but errors are ignored
  add_row(0, 1, 12'h0c8, 0, 1, 0, 0, 13'h000, 12'h000, 1, 2'd0);
  add_row(1, 1, 12'h0c8, 0, 1, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  // Prefetch off, response held and then cleared
  add_row(0, 0, 12'h0c8, 0, 0, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(0, 0, 12'h0c8, 1, 0, 0, 0, 13'h000, 12'h000, 0, 2'd0);
  add_row(0, 0, 12'h0c8, 0, 0, 0, 0, 13'h000, 12'h000, 0, 2'd0);
endtask

`endif

// ==== test/ifetch_tb.sv ====
/*
  Testbench for the fetch stage: IMEM model, cycle reference model and a
  table of per-cycle stimulus from the included table header.
*/
`include "ifetch_cfg.svh"

module ifetch_tb
  import ifetch_pkg::*;
;

  localparam int IMEM_WORDS = `IFETCH_IMEM_SIZE_BYTE / 4;

  typedef struct packed {
    logic                      req_v;
    logic                      raw_v;
    imem_addr_t                addr;
    logic                      clear;
    logic                      en;
    logic                      loop_act;
    logic [`IFETCH_LOOP_W-1:0] loop_iter;
    loop_end_addr_t            loop_end;
    imem_addr_t                loop_jump;
    logic                      ignore;
    logic [1:0]                exp_err;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic insn_fetch_req_valid_i, insn_fetch_req_valid_raw_i, insn_fetch_resp_clear_i;
  imem_addr_t insn_fetch_req_addr_i;
  logic prefetch_en_i, prefetch_loop_active_i, prefetch_ignore_errs_i;
  logic [`IFETCH_LOOP_W-1:0] prefetch_loop_iterations_i;
  loop_end_addr_t prefetch_loop_end_addr_i;
  imem_addr_t prefetch_loop_jump_addr_i;
  imem_word_t imem_rdata_i = '0;
  logic imem_rvalid_i = 1'b0;
  logic imem_req_o, insn_fetch_resp_valid_o, insn_fetch_err_o, insn_addr_err_o;
  imem_addr_t imem_addr_o, insn_fetch_resp_addr_o;
  insn_t insn_fetch_resp_data_o;

  imem_word_t mem [IMEM_WORDS];
  int         flips [IMEM_WORDS];
  row_t       rows [$];
  int         num_rows = 0;
  int         mismatch_cnt = 0;
  int         other_cnt = 0;

  // Reference model state
  imem_addr_t m_paddr = '0;
  logic       m_kill = 1'b0;
  logic       m_valid = 1'b0;
  imem_addr_t m_raddr = '0;
  insn_t      m_data = '0;
  int         m_flips = 0;

  ifetch_top dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .insn_fetch_req_valid_i(insn_fetch_req_valid_i),
    .insn_fetch_req_valid_raw_i(insn_fetch_req_valid_raw_i),
    .insn_fetch_req_addr_i(insn_fetch_req_addr_i),
    .insn_fetch_resp_clear_i(insn_fetch_resp_clear_i),
    .prefetch_en_i(prefetch_en_i),
    .prefetch_loop_active_i(prefetch_loop_active_i),
    .prefetch_loop_iterations_i(prefetch_loop_iterations_i),
    .prefetch_loop_end_addr_i(prefetch_loop_end_addr_i),
    .prefetch_loop_jump_addr_i(prefetch_loop_jump_addr_i),
    .prefetch_ignore_errs_i(prefetch_ignore_errs_i),
    .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
    .imem_rdata_i(imem_rdata_i), .imem_rvalid_i(imem_rvalid_i),
    .insn_fetch_resp_valid_o(insn_fetch_resp_valid_o),
    .insn_fetch_resp_addr_o(insn_fetch_resp_addr_o),
    .insn_fetch_resp_data_o(insn_fetch_resp_data_o),
    .insn_fetch_err_o(insn_fetch_err_o),
    .insn_addr_err_o(insn_addr_err_o)
  );

  always #20 clk_i = ~clk_i;

  // IMEM answers a request one cycle later
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imem_rvalid_i <= 1'b0;
      imem_rdata_i  <= '0;
    end else begin
      imem_rvalid_i <= imem_req_o;
      if (imem_req_o) begin
        imem_rdata_i <= mem[imem_addr_o[`IFETCH_ADDR_W-1:2]];
      end
    end
  end

  // Check bit k is the inverted parity of data bits k, k+7, k+14 and so on
  function automatic logic [`IFETCH_INTG_W-1:0] encode_intg(insn_t data);
    logic [`IFETCH_INTG_W-1:0] chk;
    for (int k = 0; k < `IFETCH_INTG_W; k++) begin
      chk[k] = 1'b1;
      for (int i = k; i < `IFETCH_INSN_W; i += `IFETCH_INTG_W) chk[k] = chk[k] ^ data[i];
    end
    return chk;
  endfunction

  task automatic fill_imem();
    insn_t data;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      // Random payload with a plain ALU opcode so no word redirects by chance
      data      = $urandom();
      data[6:0] = 7'b0110011;
      mem[i]    = {encode_intg(data), data};
      flips[i]  = 0;
    end
    data      = $urandom();
    data[6:0] = `IFETCH_OPC_BRANCH;
    mem[5]    = {encode_intg(data), data};
    // One bad check bit at 0x008, two at 0x00c
    mem[2][35] = ~mem[2][35];
    flips[2]   = 1;
    mem[3][33] = ~mem[3][33];
    mem[3][37] = ~mem[3][37];
    flips[3]   = 2;
  endtask

  task automatic add_row(logic req_v, logic raw_v, imem_addr_t addr, logic clear, logic en,
                         logic loop_act, logic [`IFETCH_LOOP_W-1:0] loop_iter,
                         loop_end_addr_t loop_end, imem_addr_t loop_jump, logic ignore,
                         logic [1:0] exp_err);
    rows.push_back({req_v, raw_v, addr, clear, en, loop_act, loop_iter, loop_end,
                    loop_jump, ignore, exp_err});
  endtask

  `include "ifetch_tb_table.svh"

  task automatic check_addr(string name, imem_addr_t act, imem_addr_t exp);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_insn(string name, insn_t act, insn_t exp);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
    end
  endtask

  task automatic apply_row(row_t r);
    insn_fetch_req_valid_i     <= r.req_v;
    insn_fetch_req_valid_raw_i <= r.raw_v;
    insn_fetch_req_addr_i      <= r.addr;
    insn_fetch_resp_clear_i    <= r.clear;
    prefetch_en_i              <= r.en;
    prefetch_loop_active_i     <= r.loop_act;
    prefetch_loop_iterations_i <= r.loop_iter;
    prefetch_loop_end_addr_i   <= r.loop_end;
    prefetch_loop_jump_addr_i  <= r.loop_jump;
    prefetch_ignore_errs_i     <= r.ignore;
  endtask

  // Predicts this cycle's outputs, compares them, then steps the model
  task automatic check_cycle(row_t r, int idx);
    logic rv_fin, differs, ctrl, loop_hit, ld, n_kill, fetch_en, exp_ferr, exp_aerr;
    imem_addr_t exp_addr;
    rv_fin   = imem_rvalid_i && !m_kill;
    differs  = (r.addr != m_paddr);
    ctrl     = (imem_rdata_i[6:0] == `IFETCH_OPC_BRANCH) ||
               (imem_rdata_i[6:0] == `IFETCH_OPC_JAL) || (imem_rdata_i[6:0] == `IFETCH_OPC_JALR);
    loop_hit = r.loop_act && ({1'b0, m_paddr} == r.loop_end) && (r.loop_iter > 1);
    ld       = r.en;
    n_kill   = 1'b0;
    exp_addr = m_paddr + 12'd4;
    if (!r.raw_v) begin
      exp_addr = m_paddr;
    end else if (!rv_fin || differs) begin
      exp_addr = r.addr;
    end else if (ctrl) begin
      n_kill = 1'b1;
      ld     = 1'b0;
    end else if (loop_hit) begin
      exp_addr = r.loop_jump;
    end
    exp_aerr = rv_fin && r.raw_v && !r.ignore && differs;
    exp_ferr = m_valid && (m_flips != 0);
    fetch_en = r.req_v && rv_fin && !differs;
    if ({exp_aerr, exp_ferr} != r.exp_err) begin
      other_cnt++;
      $display("error at %0t: row %0d lists error class %0d but the model predicts %0d",
               $time, idx, r.exp_err, {exp_aerr, exp_ferr});
    end
    check_bit("imem_req_o", imem_req_o, r.en);
    check_addr("imem_addr_o", imem_addr_o, exp_addr);
    check_bit("insn_fetch_resp_valid_o", insn_fetch_resp_valid_o, m_valid);
    if (m_valid) begin
      check_addr("insn_fetch_resp_addr_o", insn_fetch_resp_addr_o, m_raddr);
      check_insn("insn_fetch_resp_data_o", insn_fetch_resp_data_o, m_data);
    end
    check_bit("insn_fetch_err_o", insn_fetch_err_o, exp_ferr);
    check_bit("insn_addr_err_o", insn_addr_err_o, exp_aerr);
    // The response captures the word of the current prefetch address
    if (fetch_en) begin
      m_data  = imem_rdata_i[`IFETCH_INSN_W-1:0];
      m_raddr = m_paddr;
      m_flips = flips[m_paddr[`IFETCH_ADDR_W-1:2]];
    end
    m_valid = r.req_v ? fetch_en : (m_valid && !r.clear);
    m_kill  = n_kill;
    if (ld) m_paddr = exp_addr;
  endtask

  // Ends a hung run after a generous multiple of the table length
  initial begin
    wait (num_rows > 0);
    #((num_rows + 20) * 40 * 4);
    $display("timeout: the run did not finish in %0d cycles", (num_rows + 20) * 4);
    $display("test failed");
    $finish;
  end

  initial begin
    int seed_ret;
    seed_ret = $urandom(32'hc6681e19);
    rst_ni = 1'b0;
    insn_fetch_req_valid_i = 1'b0;
    insn_fetch_req_valid_raw_i = 1'b0;
    insn_fetch_req_addr_i = '0;
    insn_fetch_resp_clear_i = 1'b0;
    prefetch_en_i = 1'b0;
    prefetch_loop_active_i = 1'b0;
    prefetch_loop_iterations_i = '0;
    prefetch_loop_end_addr_i = '0;
    prefetch_loop_jump_addr_i = '0;
    prefetch_ignore_errs_i = 1'b0;
    fill_imem();
    load_table();
    num_rows = rows.size();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk_i);
      apply_row(rows[i]);
      // Outputs have settled by the falling edge
      @(negedge clk_i);
      check_cycle(rows[i], i);
    end
    $display("mismatches: %0d, other errors: %0d", mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
source/ifetch_pkg.sv
source/ifetch_intg_check.sv
source/ifetch_prefetch.sv
source/ifetch_resp.sv
source/ifetch_top.sv
test/ifetch_tb.sv
